//--- rtl/rdma_wr_pkg.sv
/*
 * Constants and stream payload types shared by the write demultiplexer:
 * region count, length and beat sizing, queue depths, the readiness
 * threshold, and the command, sequence entry and data beat structs
 */
package rdma_wr_pkg;

  // Regions
  localparam int N_REGIONS      = 4;
  localparam int N_REGIONS_BITS = 2;

  // Command length in bytes, payload beat sizing
  localparam int LEN_BITS       = 12;
  localparam int DATA_BITS      = 64;
  localparam int KEEP_BITS      = DATA_BITS / 8;
  localparam int BEAT_LOG_BITS  = 3;
  localparam int BEAT_CNT_BITS  = LEN_BITS - BEAT_LOG_BITS;

  // Queue depths and the fill level that still reports ready
  localparam int N_OUTSTANDING  = 8;
  localparam int CMD_DEPTH      = 4;
  localparam int DATA_DEPTH     = 16;
  localparam int WR_THRS        = 12;
  localparam int CNT_BITS       = 5;

  // Write command as it arrives and leaves, 16 bits
  typedef struct packed {
    logic [N_REGIONS_BITS-1:0] vfid;
    logic [LEN_BITS-1:0]       len;
    logic                      host;
    logic                      last;
  } wr_req_t;

  // Order record for payload steering, 15 bits
  typedef struct packed {
    logic                      last;
    logic [N_REGIONS_BITS-1:0] vfid;
    logic [LEN_BITS-1:0]       len;
  } seq_ent_t;

  // One payload beat, 73 bits
  typedef struct packed {
    logic [DATA_BITS-1:0] tdata;
    logic [KEEP_BITS-1:0] tkeep;
    logic                 tlast;
  } axis_beat_t;

endpackage

//--- rtl/stream_queue.sv
`timescale 1ns/1ps

/*
 * Circular-buffer FIFO for any payload type, valid/ready on both
 * sides, with an occupancy count
 */
module stream_queue
  import rdma_wr_pkg::*;
#(
  parameter type QTYPE  = logic,
  parameter int  QDEPTH = CMD_DEPTH
) (
  input  logic                aclk,
  input  logic                aresetn,
  input  logic                snk_valid,
  output logic                snk_ready,
  input  QTYPE                snk_data,
  output logic                src_valid,
  input  logic                src_ready,
  output QTYPE                src_data,
  output logic [CNT_BITS-1:0] used
);

  QTYPE                      mem [QDEPTH];
  logic [$clog2(QDEPTH)-1:0] wr_ptr;
  logic [$clog2(QDEPTH)-1:0] rd_ptr;
  logic                      wr_fire;
  logic                      rd_fire;

  // ------------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------------
  // Room and content come from the count only
  assign snk_ready = (used != CNT_BITS'(QDEPTH));
  assign src_valid = (used != '0);
  assign src_data  = mem[rd_ptr];

  assign wr_fire = snk_valid & snk_ready;
  assign rd_fire = src_valid & src_ready;

  // Word written here shows at the head from the next edge
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= snk_data;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      // Wrap at the depth rather than the pointer width
      if (wr_fire) begin
        wr_ptr <= (32'(wr_ptr) == QDEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (32'(rd_ptr) == QDEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({wr_fire, rd_fire})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

  // Full or empty count puts the write slot on the read head
  a_full_ptr_match: assert property (@(posedge aclk) disable iff (!aresetn)
    (used == CNT_BITS'(QDEPTH) || used == '0) |-> (wr_ptr == rd_ptr));

  // Occupancy bounded by the depth
  a_used_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    used <= CNT_BITS'(QDEPTH));

endmodule

//--- rtl/wr_cmd_router.sv
`timescale 1ns/1ps

/*
 * Command router that sends each write command to its region's command
 * queue and logs a sequence entry for the payload steering
 */
module wr_cmd_router
  import rdma_wr_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 s_req_valid,
  output logic                 s_req_ready,
  input  wr_req_t              s_req_data,
  output logic [N_REGIONS-1:0] cmd_valid,
  output wr_req_t              cmd_data,
  input  logic [N_REGIONS-1:0] cmd_ready,
  output logic                 seq_valid,
  input  logic                 seq_ready,
  output seq_ent_t             seq_data
);

  logic     seq_snk_valid;
  logic     seq_snk_ready;
  seq_ent_t seq_snk_data;

  // Accept only with room in both the sequence and target command queue
  assign s_req_ready   = seq_snk_ready & cmd_ready[s_req_data.vfid];
  assign seq_snk_valid = s_req_valid & s_req_ready;

  // Command leaves unchanged with its host flag
  assign cmd_data = s_req_data;

  // One-hot valid on the target region
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_cmd_valid
    assign cmd_valid[i] = seq_snk_valid & (s_req_data.vfid == N_REGIONS_BITS'(i));
  end

  // Order record with what the steer needs per command
  assign seq_snk_data = '{
    last: s_req_data.last,
    vfid: s_req_data.vfid,
    len:  s_req_data.len
  };

  stream_queue #(
    .QTYPE  (seq_ent_t),
    .QDEPTH (N_OUTSTANDING)
  ) seq_que (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .snk_valid (seq_snk_valid),
    .snk_ready (seq_snk_ready),
    .snk_data  (seq_snk_data),
    .src_valid (seq_valid),
    .src_ready (seq_ready),
    .src_data  (seq_data),
    .used      ()
  );

  // Stalled request stays offered until taken
  a_req_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    (s_req_valid && !s_req_ready) |=> s_req_valid);

  // Stalled command held by the source until taken
  a_cmd_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (s_req_valid && !s_req_ready) |=> $stable(cmd_data));

endmodule

//--- rtl/wr_data_steer.sv
`timescale 1ns/1ps

/*
 * Payload steering FSM that pops sequence entries, counts beats per
 * command and routes them to the target region with a regenerated tlast
 */
module wr_data_steer
  import rdma_wr_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 seq_valid,
  output logic                 seq_ready,
  input  seq_ent_t             seq_data,
  input  logic                 s_axis_valid,
  output logic                 s_axis_ready,
  input  axis_beat_t           s_axis_data,
  output logic [N_REGIONS-1:0] beat_valid,
  output axis_beat_t           beat_data,
  input  logic [N_REGIONS-1:0] beat_ready
);

  typedef enum logic {ST_IDLE, ST_STEER} state_t;

  state_t                    state_q;
  state_t                    state_d;
  logic [N_REGIONS_BITS-1:0] vfid_q;
  logic                      last_q;
  logic [BEAT_CNT_BITS-1:0]  cnt_q;
  logic [BEAT_CNT_BITS-1:0]  cnt_load;
  logic                      beat_fire;
  logic                      tr_done;
  logic                      load;

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------
  // Beats minus one as ceil(len/8) - 1 for a nonzero len
  assign cnt_load = (seq_data.len[BEAT_LOG_BITS-1:0] != '0) ?
                    seq_data.len[LEN_BITS-1:BEAT_LOG_BITS] :
                    seq_data.len[LEN_BITS-1:BEAT_LOG_BITS] - 1'b1;

  // Payload moves only while steering and the target has room
  assign s_axis_ready = (state_q == ST_STEER) & beat_ready[vfid_q];
  assign beat_fire    = s_axis_valid & s_axis_ready;
  assign tr_done      = beat_fire & (cnt_q == '0);

  // Pop in idle or on the final beat for back-to-back commands
  assign seq_ready = (state_q == ST_IDLE) | tr_done;
  assign load      = seq_valid & seq_ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (seq_valid) begin
          state_d = ST_STEER;
        end
      end
      ST_STEER: begin
        // Stay when the next entry is already waiting
        if (tr_done && !seq_valid) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
      vfid_q  <= '0;
      last_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        vfid_q <= seq_data.vfid;
        last_q <= seq_data.last;
        cnt_q  <= cnt_load;
      end else if (beat_fire && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_beat_valid
    assign beat_valid[i] = (state_q == ST_STEER) & s_axis_valid &
                           (vfid_q == N_REGIONS_BITS'(i));
  end

  // Incoming tlast dropped and regenerated from the count
  assign beat_data.tdata = s_axis_data.tdata;
  assign beat_data.tkeep = s_axis_data.tkeep;
  assign beat_data.tlast = last_q & (cnt_q == '0);

  // Beat offered to a full data queue keeps its payload and tlast
  a_beat_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    ((beat_valid != '0) && !s_axis_ready) |=> $stable(beat_data));

endmodule

//--- rtl/wr_region_buffer.sv
`timescale 1ns/1ps

/*
 * Per-region buffering: command queue, data queue and the
 * fill-threshold readiness flag
 */
module wr_region_buffer
  import rdma_wr_pkg::*;
(
  input  logic       aclk,
  input  logic       aresetn,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  wr_req_t    cmd_data,
  input  logic       beat_valid,
  output logic       beat_ready,
  input  axis_beat_t beat_data,
  output logic       m_req_valid,
  input  logic       m_req_ready,
  output wr_req_t    m_req_data,
  output logic       m_axis_valid,
  input  logic       m_axis_ready,
  output axis_beat_t m_axis_data,
  output logic       wr_rdy
);

  logic [CNT_BITS-1:0] data_used;

  // Commands for this region
  stream_queue #(
    .QTYPE  (wr_req_t),
    .QDEPTH (CMD_DEPTH)
  ) cmd_que (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .snk_valid (cmd_valid),
    .snk_ready (cmd_ready),
    .snk_data  (cmd_data),
    .src_valid (m_req_valid),
    .src_ready (m_req_ready),
    .src_data  (m_req_data),
    .used      ()
  );

  // Payload, full queue stalls the shared steer
  stream_queue #(
    .QTYPE  (axis_beat_t),
    .QDEPTH (DATA_DEPTH)
  ) data_que (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .snk_valid (beat_valid),
    .snk_ready (beat_ready),
    .snk_data  (beat_data),
    .src_valid (m_axis_valid),
    .src_ready (m_axis_ready),
    .src_data  (m_axis_data),
    .used      (data_used)
  );

  // Level hint, high while the fill count is at or below the threshold
  assign wr_rdy = (data_used <= CNT_BITS'(WR_THRS));

endmodule

//--- rtl/rdma_wr_mux.sv
`timescale 1ns/1ps

/*
 * Write-side demultiplexer top: command router with sequence queue,
 * payload steer and one buffer per region
 */
module rdma_wr_mux
  import rdma_wr_pkg::*;
(
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          s_req_valid,
  output logic                          s_req_ready,
  input  wr_req_t                       s_req_data,
  input  logic                          s_axis_valid,
  output logic                          s_axis_ready,
  input  axis_beat_t                    s_axis_data,
  output logic       [N_REGIONS-1:0]    m_req_valid,
  input  logic       [N_REGIONS-1:0]    m_req_ready,
  output wr_req_t    [N_REGIONS-1:0]    m_req_data,
  output logic       [N_REGIONS-1:0]    m_axis_valid,
  input  logic       [N_REGIONS-1:0]    m_axis_ready,
  output axis_beat_t [N_REGIONS-1:0]    m_axis_data,
  output logic       [N_REGIONS-1:0]    wr_rdy
);

  logic [N_REGIONS-1:0] cmd_valid;
  logic [N_REGIONS-1:0] cmd_ready;
  wr_req_t              cmd_data;
  logic                 seq_valid;
  logic                 seq_ready;
  seq_ent_t             seq_data;
  logic [N_REGIONS-1:0] beat_valid;
  logic [N_REGIONS-1:0] beat_ready;
  axis_beat_t           beat_data;

  wr_cmd_router router0 (
    .aclk, .aresetn,
    .s_req_valid, .s_req_ready, .s_req_data,
    .cmd_valid, .cmd_data, .cmd_ready,
    .seq_valid, .seq_ready, .seq_data
  );

  wr_data_steer steer0 (
    .aclk, .aresetn,
    .seq_valid, .seq_ready, .seq_data,
    .s_axis_valid, .s_axis_ready, .s_axis_data,
    .beat_valid, .beat_data, .beat_ready
  );

  // Shared command and beat payload, per-region valid and ready
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
    wr_region_buffer buf0 (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .cmd_valid    (cmd_valid[i]),
      .cmd_ready    (cmd_ready[i]),
      .cmd_data     (cmd_data),
      .beat_valid   (beat_valid[i]),
      .beat_ready   (beat_ready[i]),
      .beat_data    (beat_data),
      .m_req_valid  (m_req_valid[i]),
      .m_req_ready  (m_req_ready[i]),
      .m_req_data   (m_req_data[i]),
      .m_axis_valid (m_axis_valid[i]),
      .m_axis_ready (m_axis_ready[i]),
      .m_axis_data  (m_axis_data[i]),
      .wr_rdy       (wr_rdy[i])
    );
  end

endmodule

//--- testbench/rdma_wr_mux_tb.sv
`timescale 1ns/1ps

/*
 * Testbench for the write demultiplexer: clock, reset, random commands
 * and payload, back-pressure, reference model with per-region queues,
 * compare tasks, fill-level model for wr_rdy and a watchdog
 */
module rdma_wr_mux_tb
  import rdma_wr_pkg::*;
();

  localparam int CLK_NS      = 4;
  localparam int SEED        = 89038;
  localparam int N_CMDS      = 200;
  localparam int WATCHDOG_NS = N_CMDS * 20 * CLK_NS * 2;
  localparam int DRAIN_LIMIT = 2000;
  // Region 0 output held off for this window of cycles
  localparam int STALL_FIRST = 300;
  localparam int STALL_LAST  = 900;

  logic                          aclk;
  logic                          aresetn;
  logic                          s_req_valid;
  logic                          s_req_ready;
  wr_req_t                       s_req_data;
  logic                          s_axis_valid;
  logic                          s_axis_ready;
  axis_beat_t                    s_axis_data;
  logic       [N_REGIONS-1:0]    m_req_valid;
  logic       [N_REGIONS-1:0]    m_req_ready;
  wr_req_t    [N_REGIONS-1:0]    m_req_data;
  logic       [N_REGIONS-1:0]    m_axis_valid;
  logic       [N_REGIONS-1:0]    m_axis_ready;
  axis_beat_t [N_REGIONS-1:0]    m_axis_data;
  logic       [N_REGIONS-1:0]    wr_rdy;

  // Stimulus in issue order, expected results per region
  wr_req_t    cmd_q [$];
  axis_beat_t pay_q [$];
  int         pay_tgt_q [$];
  wr_req_t    exp_req [N_REGIONS][$];
  axis_beat_t exp_beat [N_REGIONS][$];
  // Beats the model believes sit in each data queue
  int         fill [N_REGIONS];

  rdma_wr_mux dut0 (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_NS / 2) aclk = ~aclk;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // Beats per command, bytes rounded up to whole beats
  function automatic int beats_for(logic [LEN_BITS-1:0] len);
    return (int'(len) + (1 << BEAT_LOG_BITS) - 1) / (1 << BEAT_LOG_BITS);
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int r = 0; r < N_REGIONS; r++) begin
      n += exp_req[r].size() + exp_beat[r].size();
    end
    return n;
  endfunction

  task automatic build_stimulus();
    wr_req_t    req;
    axis_beat_t beat;
    int         nb;
    for (int i = 0; i < N_CMDS; i++) begin
      req.vfid = N_REGIONS_BITS'($urandom % N_REGIONS);
      req.len  = LEN_BITS'(1 + $urandom % 100);
      req.host = 1'($urandom % 2);
      req.last = 1'($urandom % 2);
      cmd_q.push_back(req);
      exp_req[req.vfid].push_back(req);
      nb = beats_for(req.len);
      for (int b = 0; b < nb; b++) begin
        beat.tdata = {$urandom, $urandom};
        beat.tkeep = KEEP_BITS'($urandom);
        // Random input tlast, the DUT must regenerate it
        beat.tlast = 1'($urandom % 2);
        pay_q.push_back(beat);
        pay_tgt_q.push_back(int'(req.vfid));
        beat.tlast = req.last && (b == nb - 1);
        exp_beat[req.vfid].push_back(beat);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic fail_run(string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_req(int r, wr_req_t got);
    wr_req_t exp;
    if (exp_req[r].size() == 0) begin
      fail_run($sformatf("Region %0d sent a command that was never issued", r));
    end else begin
      exp = exp_req[r].pop_front();
      if (got !== exp) begin
        fail_run($sformatf("CHECK FAILED m_req_data[%0d]: got %h expected %h", r, got, exp));
      end
    end
  endtask

  task automatic check_beat(int r, axis_beat_t got);
    axis_beat_t exp;
    if (exp_beat[r].size() == 0) begin
      fail_run($sformatf("Region %0d sent a payload beat that was never issued", r));
    end else begin
      exp = exp_beat[r].pop_front();
      if (got !== exp) begin
        fail_run($sformatf("CHECK FAILED m_axis_data[%0d]: got %h expected %h", r, got, exp));
      end
    end
  endtask

  task automatic check_rdy(int r, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED wr_rdy[%0d]: got %h expected %h, fill %0d",
                         r, got, exp, fill[r]));
    end
  endtask

  // Sampled mid-cycle, all inputs settled since the 1 ns drive point
  initial begin
    forever begin
      @(negedge aclk);
      if (aresetn) begin
        for (int r = 0; r < N_REGIONS; r++) begin
          // Level reflects the count after the previous edge
          check_rdy(r, wr_rdy[r], fill[r] <= WR_THRS);
          if (m_req_valid[r] && m_req_ready[r]) begin
            check_req(r, m_req_data[r]);
          end
          if (m_axis_valid[r] && m_axis_ready[r]) begin
            check_beat(r, m_axis_data[r]);
            fill[r]--;
          end
        end
        // Accepted payload enters the current target's data queue
        if (s_axis_valid && s_axis_ready) begin
          fill[pay_tgt_q.pop_front()]++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("Timeout: traffic did not complete within the watchdog time");
  end

  // --------------------------------------------------------------------------
  // Drivers, all at 1 ns after the rising edge
  // --------------------------------------------------------------------------
  task automatic drive_reqs();
    foreach (cmd_q[i]) begin
      s_req_valid = 1'b1;
      s_req_data  = cmd_q[i];
      @(negedge aclk);
      while (!s_req_ready) @(negedge aclk);
      @(posedge aclk);
      #1;
    end
    s_req_valid = 1'b0;
  endtask

  task automatic drive_payload();
    foreach (pay_q[i]) begin
      // Occasional gap between beats
      if ($urandom % 8 == 0) begin
        s_axis_valid = 1'b0;
        @(posedge aclk);
        #1;
      end
      s_axis_valid = 1'b1;
      s_axis_data  = pay_q[i];
      @(negedge aclk);
      while (!s_axis_ready) @(negedge aclk);
      @(posedge aclk);
      #1;
    end
    s_axis_valid = 1'b0;
  endtask

  task automatic drive_ready();
    int cyc;
    cyc = 0;
    forever begin
      for (int r = 0; r < N_REGIONS; r++) begin
        m_req_ready[r]  = ($urandom % 4) != 0;
        m_axis_ready[r] = ($urandom % 4) != 0;
      end
      if (cyc >= STALL_FIRST && cyc < STALL_LAST) begin
        m_axis_ready[0] = 1'b0;
      end
      @(posedge aclk);
      #1;
      cyc++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending() != 0 && n < DRAIN_LIMIT) begin
      @(posedge aclk);
      n++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int left_r;
    void'($urandom(SEED));
    aresetn      = 1'b0;
    s_req_valid  = 1'b0;
    s_req_data   = '0;
    s_axis_valid = 1'b0;
    s_axis_data  = '0;
    m_req_ready  = '0;
    m_axis_ready = '0;
    for (int r = 0; r < N_REGIONS; r++) begin
      fill[r] = 0;
    end
    build_stimulus();
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    fork
      drive_ready();
    join_none
    fork
      drive_reqs();
      drive_payload();
    join
    wait_drain();
    // Lowest region with anything left over
    left_r = -1;
    for (int r = N_REGIONS - 1; r >= 0; r--) begin
      if (exp_req[r].size() != 0 || exp_beat[r].size() != 0) begin
        left_r = r;
      end
    end
    if (left_r >= 0) begin
      fail_run($sformatf("Region %0d still holds %0d commands and %0d beats that never left",
                         left_r, exp_req[left_r].size(), exp_beat[left_r].size()));
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

//--- rdma_wr_mux.f
rtl/rdma_wr_pkg.sv
rtl/stream_queue.sv
rtl/wr_cmd_router.sv
rtl/wr_data_steer.sv
rtl/wr_region_buffer.sv
rtl/rdma_wr_mux.sv
testbench/rdma_wr_mux_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the write demultiplexer testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rdma_wr_mux_tb \
  -f rdma_wr_mux.f -o rdma_wr_mux_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rdma_wr_mux_sim > sim.log 2>&1
cat sim.log

grep -q "^Done: no errors$" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
